//--- all.f
hw/long_div_pkg.sv
hw/div_if.sv
hw/div_cmd_queue.sv
hw/long_div_radix16.sv
hw/div_result_queue.sv
hw/div_unit_top.sv
dv/tb_clk_gen.sv
dv/div_unit_chk.sv
dv/tb_div_unit.sv

//--- Makefile
SRCS := $(shell cat all.f)

.PHONY: run clean

run: obj_dir/Vtb_div_unit
	./obj_dir/Vtb_div_unit

obj_dir/Vtb_div_unit: all.f $(SRCS)
	verilator --binary --timing --assert -f all.f --top-module tb_div_unit

clean:
	rm -rf obj_dir

//--- dv/tb_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_div_unit import long_div_pkg::*; ();

	localparam int CMD_DEPTH = 4;
	localparam int RES_DEPTH = 4;
	localparam int CONS_CREDITS = 2;
	localparam int unsigned SEED = 32'h0b388083;
	localparam int NUM_RANDOM = 120;
	// ~150 commands at 6 cycles per core round trip, plus stall and drain
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int FILL_CYCLES = 80;
	localparam int CMD_W = DIVIDEND_W + DIVISOR_W + TAG_W;

	logic clk;
	logic rst_n;
	logic cmd_valid = 1'b0;
	logic [DIVIDEND_W-1:0] cmd_dividend = '0;
	logic [DIVISOR_W-1:0] cmd_divisor = '0;
	logic [TAG_W-1:0] cmd_tag = '0;
	logic cmd_credit;
	logic res_valid;
	logic [DIVIDEND_W-1:0] res_quotient;
	logic [DIVISOR_W-1:0] res_remainder;
	logic [TAG_W-1:0] res_tag;
	logic res_credit = 1'b0;

	// {dividend, divisor, tag} in send order
	logic [CMD_W-1:0] expected [$];
	logic [CMD_W-1:0] head;
	logic [DIVIDEND_W+DIVISOR_W-1:0] ref_res;
	logic [TAG_W-1:0] next_tag = '0;
	string test_name = "reset";
	int sent_cnt = 0;
	int credit_rets = 0;
	int results_seen = 0;
	// results taken but credit not yet handed back
	int owed = 0;
	int gap_cnt = 0;
	int credit_gap = 0;
	bit hold_credits = 1'b0;
	int cycle_cnt = 0;
	int rng_init;
	int bp_base;

	tb_clk_gen #(
		.PERIOD_NS(20),
		.RESET_CYCLES(2)
	) u_tb_clk_gen (
		.clk(clk),
		.rst_n(rst_n)
	);

	div_unit_top #(
		.CMD_DEPTH(CMD_DEPTH),
		.RES_DEPTH(RES_DEPTH),
		.CONS_CREDITS(CONS_CREDITS)
	) u_div_unit_top (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd_dividend(cmd_dividend),
		.cmd_divisor(cmd_divisor),
		.cmd_tag(cmd_tag),
		.cmd_credit(cmd_credit),
		.res_valid(res_valid),
		.res_quotient(res_quotient),
		.res_remainder(res_remainder),
		.res_tag(res_tag),
		.res_credit(res_credit)
	);

	// floor quotient and remainder, {quotient, remainder}
	function automatic logic [DIVIDEND_W+DIVISOR_W-1:0] div_ref(
		input logic [DIVIDEND_W-1:0] dvd,
		input logic [DIVISOR_W-1:0] dvs
	);
		int a;
		int b;
		a = int'(dvd);
		b = int'(dvs);
		// divide by zero yields 0 and 0
		if (b == 0)
			return '0;
		return {DIVIDEND_W'(a / b), DIVISOR_W'(a % b)};
	endfunction

	// commands inside the unit, i.e. sender credits in use
	function automatic int in_flight();
		return sent_cnt - credit_rets;
	endfunction

	task automatic fail_and_stop();
		$display("** FAIL **");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check_val(input string what, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		if (exp_val !== act_val)
		begin
			$display("ERROR %s %s: expected %0d, actual %0d", test_name, what, exp_val, act_val);
			fail_and_stop();
		end
	endtask

	// drive one command this edge, no credit check
	task automatic drive_cmd(input logic [DIVIDEND_W-1:0] dvd, input logic [DIVISOR_W-1:0] dvs);
		cmd_valid <= 1'b1;
		cmd_dividend <= dvd;
		cmd_divisor <= dvs;
		cmd_tag <= next_tag;
		expected.push_back({dvd, dvs, next_tag});
		next_tag = next_tag + 1'b1;
		sent_cnt = sent_cnt + 1;
	endtask

	// waits on a sender credit
	task automatic send_cmd(input logic [DIVIDEND_W-1:0] dvd, input logic [DIVISOR_W-1:0] dvs);
		@(posedge clk);
		while (in_flight() >= CMD_DEPTH)
		begin
			cmd_valid <= 1'b0;
			@(posedge clk);
		end
		drive_cmd(dvd, dvs);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			cmd_valid <= 1'b0;
		end
	endtask

	task automatic wait_drained();
		while (expected.size() != 0 || owed != 0)
			@(posedge clk);
	endtask

	// cmd_credit pulses, seen one edge late
	always @(posedge clk)
	begin
		if (rst_n && cmd_credit)
		begin
			if (credit_rets >= sent_cnt)
			begin
				$display("cmd_credit pulsed with no command inside the unit");
				fail_and_stop();
			end
			else
				credit_rets <= credit_rets + 1;
		end
	end

	// compare each result against the oldest command
	always @(posedge clk)
	begin
		if (rst_n && res_valid)
		begin
			if (expected.size() == 0)
			begin
				$display("result with tag %0d arrived with no command outstanding", res_tag);
				fail_and_stop();
			end
			else
			begin
				head = expected.pop_front();
				ref_res = div_ref(head[CMD_W-1 -: DIVIDEND_W], head[TAG_W +: DIVISOR_W]);
				check_val("tag", 32'(head[TAG_W-1:0]), 32'(res_tag));
				check_val("quotient", 32'(ref_res[DIVISOR_W +: DIVIDEND_W]), 32'(res_quotient));
				check_val("remainder", 32'(ref_res[DIVISOR_W-1:0]), 32'(res_remainder));
				results_seen <= results_seen + 1;
			end
		end
	end

	// consumer, one credit back per result after credit_gap cycles
	always @(posedge clk)
	begin
		res_credit <= 1'b0;
		if (rst_n)
		begin
			if (res_valid)
				owed = owed + 1;
			if (!hold_credits && owed > 0)
			begin
				if (gap_cnt >= credit_gap)
				begin
					res_credit <= 1'b1;
					owed = owed - 1;
					gap_cnt = 0;
				end
				else
					gap_cnt = gap_cnt + 1;
			end
		end
	end

	always @(posedge clk)
	begin
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, %0d results still pending", cycle_cnt,
				expected.size());
			fail_and_stop();
		end
		else
			cycle_cnt <= cycle_cnt + 1;
	end

	initial
	begin
		rng_init = $urandom(SEED);
		@(posedge rst_n);
		idle_cycles(2);

		test_name = "directed_edges";
		send_cmd(16'hffff, 8'd1);
		send_cmd(16'hffff, 8'd255);
		// dividend below divisor
		send_cmd(16'd7, 8'd200);
		// exact multiple
		send_cmd(16'd3000, 8'd250);
		idle_cycles(1);
		wait_drained();

		test_name = "zero_divisor";
		send_cmd(16'd1234, 8'd0);
		// unit still works after it
		send_cmd(16'd1000, 8'd7);
		idle_cycles(1);
		wait_drained();

		test_name = "random";
		credit_gap = 2;
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			send_cmd(16'($urandom()), 8'($urandom()));
			idle_cycles(int'($urandom_range(0, 3)));
		end
		idle_cycles(1);
		wait_drained();

		// consumer withholds credits, everything backs up to the sender
		test_name = "back_pressure";
		credit_gap = 0;
		idle_cycles(2);
		hold_credits = 1'b1;
		bp_base = results_seen;
		repeat (FILL_CYCLES)
		begin
			@(posedge clk);
			if (in_flight() < CMD_DEPTH)
				drive_cmd(16'($urandom()), 8'($urandom_range(1, 255)));
			else
				cmd_valid <= 1'b0;
		end
		idle_cycles(1);
		check_val("sender credits left", 32'd0, 32'(CMD_DEPTH - in_flight()));
		check_val("results under hold", 32'(CONS_CREDITS), 32'(results_seen - bp_base));

		test_name = "drain";
		hold_credits = 1'b0;
		wait_drained();
		idle_cycles(2);

		test_name = "credit_conservation";
		check_val("sender credits", 32'(CMD_DEPTH), 32'(CMD_DEPTH - in_flight()));
		check_val("cmd_credit pulses", 32'(sent_cnt), 32'(credit_rets));

		if (expected.size() == 0 && results_seen == sent_cnt)
		begin
			$display("** PASS **");
			$finish;
		end
		else
		begin
			$display("%0d results for %0d commands at the end", results_seen, sent_cnt);
			fail_and_stop();
		end
	end

endmodule

`default_nettype wire

//--- dv/div_unit_chk.sv
`timescale 1ns/1ps
`default_nettype none

module div_unit_chk import long_div_pkg::*; #(
	parameter int RES_DEPTH = 4
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic res_valid,
	input logic core_credit,
	input logic [$clog2(RES_DEPTH + 1)-1:0] free_slots,
	input logic [DIVISOR_W-1:0] remainder,
	input logic [DIVISOR_W+DIGIT_W-1:0] div_eff
);

	localparam int SLOT_W = $clog2(RES_DEPTH + 1);
	localparam int MULT_W = DIVISOR_W + DIGIT_W;

	// no result while held in reset
	assert property (@(posedge clk) !rst_n |-> !res_valid)
		else $error("core result valid during reset");

	// result and credit go out together, one cycle after the last digit
	assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> core_credit && $past(start, NUM_DIGITS + 1))
		else $error("core result without credit return or off the digit count");

	// slot counter bounded by the result queue depth
	assert property (@(posedge clk) disable iff (!rst_n) free_slots <= SLOT_W'(RES_DEPTH))
		else $error("free slot count above result queue depth");

	// 1x entry of the table, zero divisor maps to 1 and leaves remainder 0
	assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> (MULT_W'(remainder) < div_eff))
		else $error("remainder not below divisor");

endmodule

bind long_div_radix16 div_unit_chk #(
	.RES_DEPTH(RES_DEPTH)
) u_div_unit_chk (
	.clk(clk),
	.rst_n(rst_n),
	.start(start),
	.res_valid(res.valid),
	.core_credit(cmd.credit),
	.free_slots(free_slots),
	.remainder(res.remainder),
	.div_eff(mult[1])
);

`default_nettype wire

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2) clk = ~clk;
	end

	// release lands on a rising edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- hw/div_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module div_unit_top import long_div_pkg::*; #(
	parameter int CMD_DEPTH = 4,
	parameter int RES_DEPTH = 4,
	parameter int CONS_CREDITS = 2
) (
	input logic clk,
	input logic rst_n,
	// command side, sender starts with CMD_DEPTH credits
	input logic cmd_valid,
	input logic [DIVIDEND_W-1:0] cmd_dividend,
	input logic [DIVISOR_W-1:0] cmd_divisor,
	input logic [TAG_W-1:0] cmd_tag,
	output logic cmd_credit,
	// result side, in command order
	output logic res_valid,
	output logic [DIVIDEND_W-1:0] res_quotient,
	output logic [DIVISOR_W-1:0] res_remainder,
	output logic [TAG_W-1:0] res_tag,
	input logic res_credit
);

	div_cmd_if u_cmd_if ();
	div_res_if u_res_if ();

	// front queue
	div_cmd_queue #(
		.CMD_DEPTH(CMD_DEPTH)
	) u_div_cmd_queue (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd_dividend(cmd_dividend),
		.cmd_divisor(cmd_divisor),
		.cmd_tag(cmd_tag),
		.cmd_credit(cmd_credit),
		.core(u_cmd_if)
	);

	// one division at a time
	long_div_radix16 #(
		.RES_DEPTH(RES_DEPTH)
	) u_long_div_radix16 (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(u_cmd_if),
		.res(u_res_if)
	);

	// back queue, gated by consumer credits
	div_result_queue #(
		.RES_DEPTH(RES_DEPTH),
		.CONS_CREDITS(CONS_CREDITS)
	) u_div_result_queue (
		.clk(clk),
		.rst_n(rst_n),
		.res(u_res_if),
		.res_valid(res_valid),
		.res_quotient(res_quotient),
		.res_remainder(res_remainder),
		.res_tag(res_tag),
		.res_credit(res_credit)
	);

endmodule

`default_nettype wire

//--- hw/div_result_queue.sv
`timescale 1ns/1ps
`default_nettype none

module div_result_queue import long_div_pkg::*; #(
	parameter int RES_DEPTH = 4,
	parameter int CONS_CREDITS = 2
) (
	input logic clk,
	input logic rst_n,
	div_res_if.sink res,
	output logic res_valid,
	output logic [DIVIDEND_W-1:0] res_quotient,
	output logic [DIVISOR_W-1:0] res_remainder,
	output logic [TAG_W-1:0] res_tag,
	input logic res_credit
);

	localparam int PTR_W = $clog2(RES_DEPTH);
	// headroom for credits granted ahead of results
	localparam int CRED_W = 8;

	logic [DIVIDEND_W-1:0] quo_mem [RES_DEPTH];
	logic [DIVISOR_W-1:0] rem_mem [RES_DEPTH];
	logic [TAG_W-1:0] tag_mem [RES_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic [CRED_W-1:0] cons_cnt;
	logic emit;

	// needs an entry and a consumer credit
	assign emit = (cons_cnt != '0) && (count != '0);

	assign res_valid = emit;
	assign res_quotient = quo_mem[rd_ptr];
	assign res_remainder = rem_mem[rd_ptr];
	assign res_tag = tag_mem[rd_ptr];

	// slot back to the core
	assign res.credit = emit;

	// core holds a slot for every result, never full here
	always_ff @(posedge clk)
	begin
		if (res.valid)
		begin
			quo_mem[wr_ptr] <= res.quotient;
			rem_mem[wr_ptr] <= res.remainder;
			tag_mem[wr_ptr] <= res.tag;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			cons_cnt <= CRED_W'(CONS_CREDITS);
		end
		else
		begin
			if (res.valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (emit)
				rd_ptr <= rd_ptr + 1'b1;
			if (res.valid && !emit)
				count <= count + 1'b1;
			else if (!res.valid && emit)
				count <= count - 1'b1;
			// spend on emit, grant on res_credit
			if (emit && !res_credit)
				cons_cnt <= cons_cnt - 1'b1;
			else if (!emit && res_credit)
				cons_cnt <= cons_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/long_div_radix16.sv
`timescale 1ns/1ps
`default_nettype none

module long_div_radix16 import long_div_pkg::*; #(
	parameter int RES_DEPTH = 4
) (
	input logic clk,
	input logic rst_n,
	div_cmd_if.sink cmd,
	div_res_if.source res
);

	localparam int RADIX = 2 ** DIGIT_W;
	// 15 * 255 still fits
	localparam int MULT_W = DIVISOR_W + DIGIT_W;
	localparam int CNT_W = $clog2(NUM_DIGITS);
	localparam int SLOT_W = $clog2(RES_DEPTH + 1);

	div_state_e state;

	// 1x .. 15x the divisor
	logic [MULT_W-1:0] mult [1:RADIX-1];
	logic [DIVIDEND_W-1:0] dvd;
	logic [DIVIDEND_W-1:0] quo;
	logic [DIVISOR_W-1:0] rem;
	logic [TAG_W-1:0] tag_q;
	logic [DIVISOR_W-1:0] divisor_eff;

	logic [CNT_W-1:0] cnt;
	// command captured but waiting on a result slot
	logic pending;
	logic [SLOT_W-1:0] free_slots;
	logic capture;
	logic start;

	logic [MULT_W-1:0] shifted;
	logic [MULT_W-1:0] sel_mult;
	logic [MULT_W-1:0] diff;
	logic [DIGIT_W-1:0] digit;

	assign capture = (state == DIV_IDLE) && cmd.valid;
	assign start = (state == DIV_IDLE) && (cmd.valid || pending) && (free_slots != '0);

	// zero divisor gets the 1..15 table, dividend forced to zero below
	assign divisor_eff = (cmd.divisor == '0) ? DIVISOR_W'(1) : cmd.divisor;

	// bring down the next dividend digit
	assign shifted = {rem, dvd[DIVIDEND_W-1 -: DIGIT_W]};

	// four-level search, msb of the digit first
	always_comb
	begin : digit_search
		logic [DIGIT_W-1:0] trial;
		digit = '0;
		sel_mult = '0;
		for (int b = DIGIT_W - 1; b >= 0; b--)
		begin
			trial = digit | DIGIT_W'(1 << b);
			if (mult[trial] <= shifted)
			begin
				digit = trial;
				sel_mult = mult[trial];
			end
		end
	end

	// always below the divisor, upper bits drop
	assign diff = shifted - sel_mult;

	assign res.quotient = quo;
	assign res.remainder = rem;
	assign res.tag = tag_q;

	// datapath
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			for (int k = 1; k < RADIX; k++)
				mult[k] <= MULT_W'(divisor_eff * k);
			dvd <= (cmd.divisor == '0) ? '0 : cmd.dividend;
			rem <= '0;
			tag_q <= cmd.tag;
		end
		else if (state == DIV_WORK)
		begin
			dvd <= dvd << DIGIT_W;
			rem <= diff[DIVISOR_W-1:0];
			quo <= {quo[DIVIDEND_W-DIGIT_W-1:0], digit};
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= DIV_IDLE;
			cnt <= '0;
			pending <= 1'b0;
			res.valid <= 1'b0;
			cmd.credit <= 1'b0;
		end
		else
		begin
			res.valid <= 1'b0;
			cmd.credit <= 1'b0;
			case (state)
				DIV_IDLE:
				begin
					if (start)
					begin
						state <= DIV_WORK;
						cnt <= CNT_W'(NUM_DIGITS - 1);
						pending <= 1'b0;
					end
					else if (cmd.valid)
					begin
						pending <= 1'b1;
					end
				end
				DIV_WORK:
				begin
					cnt <= cnt - 1'b1;
					// last digit, result and credit next cycle
					if (cnt == '0)
					begin
						state <= DIV_IDLE;
						res.valid <= 1'b1;
						cmd.credit <= 1'b1;
					end
				end
				default:
					state <= DIV_IDLE;
			endcase
		end
	end

	// free result slots, spent on start
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			free_slots <= SLOT_W'(RES_DEPTH);
		else if (start && !res.credit)
			free_slots <= free_slots - 1'b1;
		else if (!start && res.credit)
			free_slots <= free_slots + 1'b1;
	end

endmodule

`default_nettype wire

//--- hw/div_cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none

module div_cmd_queue import long_div_pkg::*; #(
	parameter int CMD_DEPTH = 4
) (
	input logic clk,
	input logic rst_n,
	input logic cmd_valid,
	input logic [DIVIDEND_W-1:0] cmd_dividend,
	input logic [DIVISOR_W-1:0] cmd_divisor,
	input logic [TAG_W-1:0] cmd_tag,
	output logic cmd_credit,
	div_cmd_if.source core
);

	localparam int PTR_W = $clog2(CMD_DEPTH);

	// entry storage
	logic [DIVIDEND_W-1:0] dividend_mem [CMD_DEPTH];
	logic [DIVISOR_W-1:0] divisor_mem [CMD_DEPTH];
	logic [TAG_W-1:0] tag_mem [CMD_DEPTH];

	// pointers wrap on their own, depth is a power of two
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;

	// single credit toward the core
	logic core_credit;
	logic issue;

	// head goes out the cycle it is both present and allowed
	assign issue = core_credit && (count != '0);

	assign core.valid = issue;
	assign core.dividend = dividend_mem[rd_ptr];
	assign core.divisor = divisor_mem[rd_ptr];
	assign core.tag = tag_mem[rd_ptr];

	// slot freed, sender gets one back
	assign cmd_credit = issue;

	// sender owns the credits, no full check here
	always_ff @(posedge clk)
	begin
		if (cmd_valid)
		begin
			dividend_mem[wr_ptr] <= cmd_dividend;
			divisor_mem[wr_ptr] <= cmd_divisor;
			tag_mem[wr_ptr] <= cmd_tag;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			// core starts out ready
			core_credit <= 1'b1;
		end
		else
		begin
			if (cmd_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (issue)
				rd_ptr <= rd_ptr + 1'b1;
			if (cmd_valid && !issue)
				count <= count + 1'b1;
			else if (!cmd_valid && issue)
				count <= count - 1'b1;
			// spent on issue, refilled by the core's pulse
			if (issue)
				core_credit <= 1'b0;
			else if (core.credit)
				core_credit <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/div_if.sv
`timescale 1ns/1ps
`default_nettype none

// command channel, queue to core
interface div_cmd_if import long_div_pkg::*; ();

	logic valid;
	logic [DIVIDEND_W-1:0] dividend;
	logic [DIVISOR_W-1:0] divisor;
	logic [TAG_W-1:0] tag;
	// one-cycle pulse, core back to idle
	logic credit;

	modport source (output valid, dividend, divisor, tag, input credit);
	modport sink (input valid, dividend, divisor, tag, output credit);

endinterface

// result channel, core to result queue
interface div_res_if import long_div_pkg::*; ();

	logic valid;
	logic [DIVIDEND_W-1:0] quotient;
	logic [DIVISOR_W-1:0] remainder;
	logic [TAG_W-1:0] tag;
	// one pulse per entry leaving the result queue
	logic credit;

	modport source (output valid, quotient, remainder, tag, input credit);
	modport sink (input valid, quotient, remainder, tag, output credit);

endinterface

`default_nettype wire

//--- hw/long_div_pkg.sv
`default_nettype none

package long_div_pkg;

	// dividend and quotient width
	localparam int DIVIDEND_W = 16;

	// divisor and remainder width
	localparam int DIVISOR_W = 8;

	// command tag, echoed with the result
	localparam int TAG_W = 4;

	// radix 16, one hex digit per step
	localparam int DIGIT_W = 4;
	localparam int NUM_DIGITS = DIVIDEND_W / DIGIT_W;

	// core FSM, one bit is enough
	typedef enum logic
	{
		DIV_IDLE,
		DIV_WORK
	} div_state_e;

endpackage

`default_nettype wire
